//--- vlog.f
logic/backend_pkg.sv
logic/fdiv_pkg.sv
logic/fdiv_issue_if.sv
logic/fdiv_issue_queue.sv
logic/fdiv_mant_divider.sv
logic/fdiv_unit.sv
logic/fdiv_top.sv
testbench/fdiv_sva.sv
testbench/tb_fdiv_top.sv

//--- Bender.yml
package:
  name: fdiv_backend

sources:
  - files:
      - logic/backend_pkg.sv
      - logic/fdiv_pkg.sv
      - logic/fdiv_issue_if.sv
      - logic/fdiv_issue_queue.sv
      - logic/fdiv_mant_divider.sv
      - logic/fdiv_unit.sv
      - logic/fdiv_top.sv
  - target: test
    files:
      - testbench/fdiv_sva.sv
      - testbench/tb_fdiv_top.sv

//--- testbench/tb_fdiv_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fdiv_top;
    import backend_pkg::*;
    import fdiv_pkg::*;

    localparam int          QUEUE_DEPTH = 4;
    localparam int          NUM_CYCLES  = 6000;
    localparam logic [31:0] LFSR_SEED   = 32'heef7_3360;

    // one dispatched operation and what it must deliver
    typedef struct {
        rob_idx_t rob;
        preg_t    rd;
        fp32_t    data;
        fflags_t  flags;
        bit       wb_done;
        bit       wk_done;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     dispatch_valid_i;
    logic     dispatch_ready_o;
    fp32_t    dispatch_a_i;
    fp32_t    dispatch_b_i;
    rm_e      dispatch_rm_i;
    preg_t    dispatch_rd_i;
    rob_idx_t dispatch_rob_idx_i;
    rm_e      frm_i;
    logic     redirect_i;
    rob_idx_t redirect_rob_idx_i;
    logic     wakeup_valid_o;
    logic     wakeup_ready_i;
    preg_t    wakeup_rd_o;
    logic     wb_valid_o;
    logic     wb_ready_i;
    fp32_t    wb_data_o;
    fflags_t  wb_fflags_o;
    preg_t    wb_rd_o;
    rob_idx_t wb_rob_idx_o;

    logic [31:0] lfsr_state;
    exp_t        exp_q[$];   // oldest first
    rob_idx_t    rob_next;
    bit          disp_held;
    int          accepted;
    int          stall_start;
    int          waited;

    fdiv_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s (at %0t ns)", what, $time);
        abort_run();
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [3:0]  kind;
        logic        s;
        logic [7:0]  e;
        logic [22:0] f;
        kind = 4'(rand_bits(4));
        s    = (rand_bits(1) != 0);
        f    = 23'(rand_bits(23));
        if (rand_bits(1) != 0) begin
            e = 8'd120 + 8'(rand_bits(4));   // near one, fewer overflows
        end else begin
            e = 8'(rand_bits(8));
        end
        if (e == 8'h00) e = 8'h01;
        if (e == 8'hff) e = 8'hfe;
        case (kind)
            4'd0:    return {s, 31'd0};
            4'd1:    return {s, 8'hff, 23'd0};
            4'd2:    return {s, 8'hff, f | 23'd1};
            4'd3:    return {s, 8'h00, f};          // subnormal
            4'd4:    return {s, e, 23'd0};          // exact quotients
            default: return {s, e, f};
        endcase
    endfunction

    // {result, flags NV DZ OF UF NX}
    function automatic logic [36:0] fdiv_model(input logic [31:0] a, input logic [31:0] b,
                                               input logic rtz);
        logic        s;
        logic        a0, b0, ai, bi, an, bn;
        logic [23:0] mb;
        logic [49:0] num, q, r;
        logic        up;
        int          e;
        s  = a[31] ^ b[31];
        a0 = (a[30:23] == 8'h00);
        b0 = (b[30:23] == 8'h00);
        ai = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
        bi = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
        an = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        bn = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        if (an || bn || (a0 && b0) || (ai && bi)) return {32'h7fc0_0000, 5'b10000};
        if (ai) return {s, 31'h7f80_0000, 5'b00000};
        if (b0) return {s, 31'h7f80_0000, 5'b01000};
        if (a0 || bi) return {s, 31'd0, 5'b00000};
        mb  = {1'b1, b[22:0]};
        e   = int'(a[30:23]) - int'(b[30:23]) + 127;
        num = 50'({1'b1, a[22:0]}) << 23;
        if ({1'b1, a[22:0]} < mb) begin
            num = num << 1;   // quotient below one
            e   = e - 1;
        end
        q  = num / 50'(mb);
        r  = num % 50'(mb);
        up = !rtz && (((r << 1) > 50'(mb)) || (((r << 1) == 50'(mb)) && q[0]));
        q  = q + 50'(up);
        if (q[24]) begin
            q = q >> 1;
            e = e + 1;
        end
        if (e >= 255) return {s, (rtz ? 31'h7f7f_ffff : 31'h7f80_0000), 5'b00101};
        if (e <= 0) return {s, 31'd0, 5'b00011};
        return {s, e[7:0], q[22:0], 4'b0000, (r != 0)};
    endfunction

    task automatic check_writeback();
        assert (exp_q.size() > 0 && !exp_q[0].wb_done)
            else plain_error("writeback with no operation waiting for one");
        assert (wb_rob_idx_o === exp_q[0].rob)
            else value_error("wb_rob_idx_o", 32'(exp_q[0].rob), 32'(wb_rob_idx_o));
        assert (wb_rd_o === exp_q[0].rd)
            else value_error("wb_rd_o", 32'(exp_q[0].rd), 32'(wb_rd_o));
        assert (wb_data_o === exp_q[0].data)
            else value_error("wb_data_o", exp_q[0].data, wb_data_o);
        assert (wb_fflags_o === exp_q[0].flags)
            else value_error("wb_fflags_o", 32'(exp_q[0].flags), 32'(wb_fflags_o));
        exp_q[0].wb_done = 1'b1;
    endtask

    task automatic check_wakeup();
        assert (exp_q.size() > 0 && !exp_q[0].wk_done)
            else plain_error("wakeup with no operation waiting for one");
        assert (wakeup_rd_o === exp_q[0].rd)
            else value_error("wakeup_rd_o", 32'(exp_q[0].rd), 32'(wakeup_rd_o));
        exp_q[0].wk_done = 1'b1;
    endtask

    // ready_mode 0 stalled, 1 random, 2 always ready
    task automatic step_cycle(input bit new_ops, input bit redirects, input int ready_mode);
        int          k;
        logic [1:0]  sel;
        logic        rtz;
        logic [36:0] res;
        exp_t        e;
        @(negedge clk);
        redirect_i     = 1'b0;
        wb_ready_i     = (ready_mode == 2) || (ready_mode == 1 && rand_bits(2) != 0);
        wakeup_ready_i = (ready_mode == 2) || (ready_mode == 1 && rand_bits(2) != 0);
        if (rand_bits(4) == 0) frm_i = (rand_bits(1) != 0) ? RTZ : RNE;
        if (!disp_held) begin
            dispatch_valid_i = 1'b0;
            if (redirects && rand_bits(6) == 0) begin
                k                  = int'(rand_bits(3)) % (exp_q.size() + 1);
                rob_next           = rob_next - rob_idx_t'(k);   // youngest k die
                redirect_i         = 1'b1;
                redirect_rob_idx_i = rob_next;
                wb_ready_i         = 1'b0;
                wakeup_ready_i     = 1'b0;
                for (int i = 0; i < k; i++) exp_q.delete(exp_q.size() - 1);
            end else if (new_ops && rand_bits(2) != 0) begin
                sel                = 2'(rand_bits(2));
                dispatch_valid_i   = 1'b1;
                dispatch_a_i       = rand_operand();
                dispatch_b_i       = rand_operand();
                dispatch_rm_i      = (sel == 2'd0) ? RNE : (sel == 2'd1) ? RTZ : DYN;
                dispatch_rd_i      = preg_t'(rand_bits(7));
                dispatch_rob_idx_i = rob_next;
            end
        end
        // book what happens at the coming rising edge
        if (dispatch_valid_i && dispatch_ready_o) begin
            rtz = (dispatch_rm_i == RTZ) || (dispatch_rm_i == DYN && frm_i == RTZ);
            res = fdiv_model(dispatch_a_i, dispatch_b_i, rtz);
            e   = '{rob: dispatch_rob_idx_i, rd: dispatch_rd_i, data: res[36:5],
                    flags: res[4:0], wb_done: 1'b0, wk_done: 1'b0};
            exp_q.push_back(e);
            rob_next = rob_next + 1'b1;
            accepted++;
        end
        disp_held = dispatch_valid_i && !dispatch_ready_o;
        if (wb_valid_o && wb_ready_i) check_writeback();
        if (wakeup_valid_o && wakeup_ready_i) check_wakeup();
        if (exp_q.size() > 0 && exp_q[0].wb_done && exp_q[0].wk_done) exp_q.delete(0);
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while ((exp_q.size() > 0 || disp_held) && n < 2000) begin
            step_cycle(1'b0, 1'b0, 1);
            n++;
        end
        assert (exp_q.size() == 0 && !disp_held)
            else plain_error("timed out waiting for outstanding results");
    endtask

    initial begin
        lfsr_state         = LFSR_SEED;
        rst                = 1'b1;
        dispatch_valid_i   = 1'b0;
        dispatch_a_i       = '0;
        dispatch_b_i       = '0;
        dispatch_rm_i      = RNE;
        dispatch_rd_i      = '0;
        dispatch_rob_idx_i = '0;
        frm_i              = RNE;
        redirect_i         = 1'b0;
        redirect_rob_idx_i = '0;
        wakeup_ready_i     = 1'b0;
        wb_ready_i         = 1'b0;
        rob_next           = '0;
        disp_held          = 1'b0;
        accepted           = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        assert (wb_valid_o === 1'b0) else value_error("wb_valid_o", 32'(0), 32'(wb_valid_o));
        assert (wakeup_valid_o === 1'b0)
            else value_error("wakeup_valid_o", 32'(0), 32'(wakeup_valid_o));
        assert (dispatch_ready_o === 1'b1)
            else value_error("dispatch_ready_o", 32'(1), 32'(dispatch_ready_o));

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            step_cycle(1'b1, 1'b1, 1);
        end
        drain_all();

        // outputs held off, unit takes one and the queue fills behind it
        stall_start = accepted;
        waited      = 0;
        while (dispatch_ready_o && waited < 200) begin
            step_cycle(1'b1, 1'b0, 0);
            waited++;
        end
        assert (!dispatch_ready_o)
            else plain_error("dispatch_ready_o never dropped with both outputs stalled");
        assert (accepted - stall_start == QUEUE_DEPTH + 1)
            else value_error("accepted operations", 32'(QUEUE_DEPTH + 1),
                             32'(accepted - stall_start));
        drain_all();

        repeat (2) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/fdiv_sva.sv
`timescale 1ns/1ns
`default_nettype none

module fdiv_sva #(
    parameter int DEPTH = 4
) (
    input logic             clk,
    input logic             rst,
    input logic             redirect_i,
    input logic             dispatch_ready_i,
    input logic             enq_i,            // entry written
    input logic             deq_i,            // entry sent to the unit
    input logic [DEPTH-1:0] flush_i,          // entries dropped by a redirect
    input logic             wb_valid_i,
    input logic             wb_ready_i,
    input logic [49:0]      wb_payload_i,     // data flags rd rob
    input logic             wakeup_valid_i,
    input logic             wakeup_ready_i,
    input logic [6:0]       wakeup_rd_i
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] occupancy;   // queue fill counted from its own events

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + CNT_W'(enq_i) - CNT_W'(deq_i)
                         - CNT_W'($countones(flush_i));
        end
    end

    // an offered result waits for ready unless a redirect takes it away
    wb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_valid_i && !wb_ready_i && !redirect_i) |=> (wb_valid_i && $stable(wb_payload_i)))
        else $error("writeback dropped or changed before wb_ready_i");

    wakeup_hold: assert property (@(posedge clk) disable iff (rst)
        (wakeup_valid_i && !wakeup_ready_i && !redirect_i)
            |=> (wakeup_valid_i && $stable(wakeup_rd_i)))
        else $error("wakeup dropped or changed before wakeup_ready_i");

    full_stalls: assert property (@(posedge clk) disable iff (rst)
        (occupancy == CNT_W'(DEPTH)) |-> !dispatch_ready_i)
        else $error("dispatch_ready_o high with a full issue queue");

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> (!wb_valid_i && !wakeup_valid_i))
        else $error("result offered during reset");

endmodule

bind fdiv_top fdiv_sva #(
    .DEPTH (QUEUE_DEPTH)
) u_sva (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect_i),
    .dispatch_ready_i (dispatch_ready_o),
    .enq_i            (u_queue.dispatch_fire && !u_queue.dispatch_kill),
    .deq_i            (u_queue.issue_fire),
    .flush_i          (u_queue.ent_kill),
    .wb_valid_i       (wb_valid_o),
    .wb_ready_i       (wb_ready_i),
    .wb_payload_i     ({wb_data_o, wb_fflags_o, wb_rd_o, wb_rob_idx_o}),
    .wakeup_valid_i   (wakeup_valid_o),
    .wakeup_ready_i   (wakeup_ready_i),
    .wakeup_rd_i      (wakeup_rd_o)
);

`default_nettype wire

//--- logic/fdiv_top.sv
`timescale 1ns/1ns
`default_nettype none

module fdiv_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    // dispatch
    input  logic                  dispatch_valid_i,
    output logic                  dispatch_ready_o,
    input  fdiv_pkg::fp32_t       dispatch_a_i,
    input  fdiv_pkg::fp32_t       dispatch_b_i,
    input  fdiv_pkg::rm_e         dispatch_rm_i,
    input  backend_pkg::preg_t    dispatch_rd_i,
    input  backend_pkg::rob_idx_t dispatch_rob_idx_i,
    input  fdiv_pkg::rm_e         frm_i,
    input  logic                  redirect_i,
    input  backend_pkg::rob_idx_t redirect_rob_idx_i,
    // wakeup
    output logic                  wakeup_valid_o,
    input  logic                  wakeup_ready_i,
    output backend_pkg::preg_t    wakeup_rd_o,
    // writeback
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output fdiv_pkg::fp32_t       wb_data_o,
    output fdiv_pkg::fflags_t     wb_fflags_o,
    output backend_pkg::preg_t    wb_rd_o,
    output backend_pkg::rob_idx_t wb_rob_idx_o
);

    fdiv_issue_if issue_if ();

    fdiv_issue_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .dispatch_a_i       (dispatch_a_i),
        .dispatch_b_i       (dispatch_b_i),
        .dispatch_rm_i      (dispatch_rm_i),
        .dispatch_rd_i      (dispatch_rd_i),
        .dispatch_rob_idx_i (dispatch_rob_idx_i),
        .frm_i              (frm_i),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .issue              (issue_if.queue)
    );

    fdiv_unit u_unit (
        .clk                (clk),
        .rst                (rst),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .issue              (issue_if.unit),
        .wakeup_valid_o     (wakeup_valid_o),
        .wakeup_ready_i     (wakeup_ready_i),
        .wakeup_rd_o        (wakeup_rd_o),
        .wb_valid_o         (wb_valid_o),
        .wb_ready_i         (wb_ready_i),
        .wb_data_o          (wb_data_o),
        .wb_fflags_o        (wb_fflags_o),
        .wb_rd_o            (wb_rd_o),
        .wb_rob_idx_o       (wb_rob_idx_o)
    );

endmodule

`default_nettype wire

//--- logic/fdiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fdiv_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_i,
    input  backend_pkg::rob_idx_t redirect_rob_idx_i,
    fdiv_issue_if.unit            issue,
    output logic                  wakeup_valid_o,
    input  logic                  wakeup_ready_i,
    output backend_pkg::preg_t    wakeup_rd_o,
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output fdiv_pkg::fp32_t       wb_data_o,
    output fdiv_pkg::fflags_t     wb_fflags_o,
    output backend_pkg::preg_t    wb_rd_o,
    output backend_pkg::rob_idx_t wb_rob_idx_o
);
    import backend_pkg::*;
    import fdiv_pkg::*;

    typedef enum logic [1:0] {IDLE, DIVIDE, ROUND, DELIVER} state_e;

    state_e            state_q;
    redirect_t         redir;
    logic              issue_fire;
    logic              kill_held;
    fexp_t             ea, eb;
    logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic              res_sign;
    logic              special;
    fp32_t             spec_data;
    fflags_t           spec_flags;
    logic              sign_q;
    rm_e               rm_q;
    preg_t             rd_q;
    rob_idx_t          rob_q;
    logic signed [9:0] exp_q;
    logic              div_start, div_busy, div_done, div_sticky;
    logic [25:0]       div_quot;
    fman_t             man;
    logic              guard, sticky, round_up;
    logic [24:0]       man_rnd;
    logic signed [9:0] exp_pre, exp_rnd;
    fp32_t             rnd_data;
    fflags_t           rnd_flags;

    assign redir      = '{valid: redirect_i, rob_idx: redirect_rob_idx_i};
    assign kill_held  = (state_q != IDLE) && rob_killed(redir, rob_q);
    assign issue.ready = (state_q == IDLE);
    assign issue_fire = issue.valid && issue.ready;

    // unpack, subnormals count as zero
    assign ea       = issue.a[30:23];
    assign eb       = issue.b[30:23];
    assign a_zero   = (ea == '0);
    assign b_zero   = (eb == '0);
    assign a_inf    = (ea == EXP_MAX) && (issue.a[22:0] == '0);
    assign b_inf    = (eb == EXP_MAX) && (issue.b[22:0] == '0);
    assign a_nan    = (ea == EXP_MAX) && (issue.a[22:0] != '0);
    assign b_nan    = (eb == EXP_MAX) && (issue.b[22:0] != '0);
    assign res_sign = issue.a[31] ^ issue.b[31];

    always_comb begin
        special    = 1'b1;
        spec_flags = '0;
        spec_data  = {res_sign, 31'd0};   // signed zero unless below
        if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
            spec_data  = FP32_QNAN;
            spec_flags = FLAG_NV;
        end else if (a_inf) begin
            spec_data = fp32_signed(res_sign, FP32_INF);
        end else if (b_zero) begin
            spec_data  = fp32_signed(res_sign, FP32_INF);
            spec_flags = FLAG_DZ;
        end else if (!(a_zero || b_inf)) begin
            special = 1'b0;
        end
    end

    assign div_start = issue_fire && !special;

    fdiv_mant_divider u_mant_div (
        .clk        (clk),
        .rst        (rst),
        .start_i    (div_start),
        .kill_i     (kill_held && div_busy),
        .dividend_i ({1'b1, issue.a[22:0]}),
        .divisor_i  ({1'b1, issue.b[22:0]}),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quotient_o (div_quot),
        .sticky_o   (div_sticky)
    );

    // normalize, quotient lies in [0.5, 2)
    always_comb begin
        if (div_quot[25]) begin
            man     = div_quot[25:2];
            guard   = div_quot[1];
            sticky  = div_quot[0] | div_sticky;
            exp_pre = exp_q;
        end else begin
            man     = div_quot[24:1];
            guard   = div_quot[0];
            sticky  = div_sticky;
            exp_pre = exp_q - 10'sd1;
        end
        round_up = (rm_q == RNE) && guard && (sticky || man[0]);
        man_rnd  = {1'b0, man} + {24'd0, round_up};
        exp_rnd  = exp_pre + {9'd0, man_rnd[24]};   // carry out of the mantissa
        if (exp_rnd >= 10'sd255) begin
            rnd_data  = (rm_q == RTZ) ? fp32_signed(sign_q, FP32_MAXF)
                                      : fp32_signed(sign_q, FP32_INF);
            rnd_flags = FLAG_OF | FLAG_NX;
        end else if (exp_rnd <= 10'sd0) begin
            rnd_data  = {sign_q, 31'd0};   // flush
            rnd_flags = FLAG_UF | FLAG_NX;
        end else begin
            rnd_data  = {sign_q, exp_rnd[7:0], man_rnd[22:0]};
            rnd_flags = (guard || sticky) ? FLAG_NX : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= IDLE;
            wb_valid_o     <= 1'b0;
            wakeup_valid_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue_fire && special) begin
                        state_q        <= DELIVER;
                        wb_valid_o     <= 1'b1;
                        wakeup_valid_o <= 1'b1;
                    end else if (issue_fire) begin
                        state_q <= DIVIDE;
                    end
                end
                DIVIDE: begin
                    if (kill_held) begin
                        state_q <= IDLE;
                    end else if (div_done) begin
                        state_q <= ROUND;
                    end
                end
                ROUND: begin
                    if (kill_held) begin
                        state_q <= IDLE;
                    end else begin
                        state_q        <= DELIVER;
                        wb_valid_o     <= 1'b1;
                        wakeup_valid_o <= 1'b1;
                    end
                end
                DELIVER: begin
                    if (kill_held) begin
                        state_q        <= IDLE;
                        wb_valid_o     <= 1'b0;
                        wakeup_valid_o <= 1'b0;
                    end else begin
                        if (wb_ready_i) begin
                            wb_valid_o <= 1'b0;
                        end
                        if (wakeup_ready_i) begin
                            wakeup_valid_o <= 1'b0;
                        end
                        // leave once both handshakes are through
                        if ((!wb_valid_o || wb_ready_i) && (!wakeup_valid_o || wakeup_ready_i)) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            sign_q      <= res_sign;
            rm_q        <= issue.rm;
            rd_q        <= issue.rd;
            rob_q       <= issue.rob_idx;
            exp_q       <= $signed({2'b00, ea}) - $signed({2'b00, eb}) + $signed({2'b00, EXP_BIAS});
            wb_data_o   <= spec_data;
            wb_fflags_o <= spec_flags;
        end else if (state_q == ROUND) begin
            wb_data_o   <= rnd_data;
            wb_fflags_o <= rnd_flags;
        end
    end

    assign wakeup_rd_o  = rd_q;
    assign wb_rd_o      = rd_q;
    assign wb_rob_idx_o = rob_q;

endmodule

`default_nettype wire

//--- logic/fdiv_mant_divider.sv
`timescale 1ns/1ns
`default_nettype none

module fdiv_mant_divider (
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  logic            kill_i,
    input  fdiv_pkg::fman_t dividend_i,
    input  fdiv_pkg::fman_t divisor_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [25:0]     quotient_o,
    output logic            sticky_o
);
    import fdiv_pkg::*;

    localparam int STEPS = 26;

    logic [24:0] rem_q;
    logic [24:0] rem_cur;
    logic [24:0] rem_next;
    fman_t       dvsr_q;
    fman_t       dvsr_cur;
    logic [25:0] diff;
    logic        q_bit;
    logic [4:0]  count_q;

    // first step runs on the start edge itself
    assign rem_cur  = start_i ? {1'b0, dividend_i} : rem_q;
    assign dvsr_cur = start_i ? divisor_i : dvsr_q;

    assign diff     = {1'b0, rem_cur} - {2'b00, dvsr_cur};
    assign q_bit    = ~diff[25];
    assign rem_next = q_bit ? {diff[23:0], 1'b0} : {rem_cur[23:0], 1'b0};

    assign done_o   = busy_o && (count_q == 5'(STEPS - 1));   // last step this edge
    assign sticky_o = |rem_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o  <= 1'b0;
            count_q <= '0;
        end else if (kill_i) begin
            busy_o  <= 1'b0;
        end else if (start_i) begin
            busy_o  <= 1'b1;
            count_q <= 5'd1;
        end else if (busy_o) begin
            count_q <= count_q + 5'd1;
            if (done_o) begin
                busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i || busy_o) begin
            rem_q      <= rem_next;
            quotient_o <= {quotient_o[24:0], q_bit};
        end
        if (start_i) begin
            dvsr_q <= divisor_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/fdiv_issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

module fdiv_issue_queue #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid_i,
    output logic                 dispatch_ready_o,
    input  fdiv_pkg::fp32_t      dispatch_a_i,
    input  fdiv_pkg::fp32_t      dispatch_b_i,
    input  fdiv_pkg::rm_e        dispatch_rm_i,
    input  backend_pkg::preg_t   dispatch_rd_i,
    input  backend_pkg::rob_idx_t dispatch_rob_idx_i,
    input  fdiv_pkg::rm_e        frm_i,
    input  logic                 redirect_i,
    input  backend_pkg::rob_idx_t redirect_rob_idx_i,
    fdiv_issue_if.queue          issue
);
    import backend_pkg::*;
    import fdiv_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_kill;
    logic [DEPTH-1:0] ent_live;
    fp32_t            ent_a   [DEPTH];
    fp32_t            ent_b   [DEPTH];
    rm_e              ent_rm  [DEPTH];
    preg_t            ent_rd  [DEPTH];
    rob_idx_t         ent_rob [DEPTH];

    redirect_t        redir;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_found;
    logic [IDX_W-1:0] free_idx;
    logic             dispatch_fire;
    logic             dispatch_kill;
    logic             issue_fire;
    rm_e              rm_resolved;

    assign redir = '{valid: redirect_i, rob_idx: redirect_rob_idx_i};

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_kill[i] = ent_valid[i] && rob_killed(redir, ent_rob[i]);
        end
    end

    assign ent_live = ent_valid & ~ent_kill;   // dying entries are never offered

    // oldest live entry by rob age
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_live[i] && (!sel_found || rob_older(ent_rob[i], ent_rob[sel_idx]))) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // first empty slot
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign dispatch_ready_o = ~&ent_valid;
    assign dispatch_fire    = dispatch_valid_i && dispatch_ready_o;
    assign dispatch_kill    = rob_killed(redir, dispatch_rob_idx_i);
    assign rm_resolved      = (dispatch_rm_i == DYN) ? frm_i : dispatch_rm_i;

    assign issue.valid   = sel_found;
    assign issue.a       = ent_a[sel_idx];
    assign issue.b       = ent_b[sel_idx];
    assign issue.rm      = ent_rm[sel_idx];
    assign issue.rd      = ent_rd[sel_idx];
    assign issue.rob_idx = ent_rob[sel_idx];
    assign issue_fire    = issue.valid && issue.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
        end else begin
            ent_valid <= ent_valid & ~ent_kill;
            if (issue_fire) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            if (dispatch_fire && !dispatch_kill) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            ent_a[free_idx]   <= dispatch_a_i;
            ent_b[free_idx]   <= dispatch_b_i;
            ent_rm[free_idx]  <= rm_resolved;
            ent_rd[free_idx]  <= dispatch_rd_i;
            ent_rob[free_idx] <= dispatch_rob_idx_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/fdiv_issue_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fdiv_issue_if;
    import backend_pkg::*;
    import fdiv_pkg::*;

    logic     valid;
    fp32_t    a;
    fp32_t    b;
    rm_e      rm;       // already resolved, RNE or RTZ
    preg_t    rd;
    rob_idx_t rob_idx;
    logic     ready;

    modport queue (
        output valid, a, b, rm, rd, rob_idx,
        input  ready
    );

    modport unit (
        input  valid, a, b, rm, rd, rob_idx,
        output ready
    );

endinterface

`default_nettype wire

//--- logic/fdiv_pkg.sv
`default_nettype none

package fdiv_pkg;

    typedef logic [31:0] fp32_t;
    typedef logic [7:0]  fexp_t;
    typedef logic [23:0] fman_t;   // hidden bit included

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        DYN = 3'b111    // take frm from the top level
    } rm_e;

    // order is NV DZ OF UF NX
    typedef logic [4:0] fflags_t;

    localparam fflags_t FLAG_NV = 5'b10000;
    localparam fflags_t FLAG_DZ = 5'b01000;
    localparam fflags_t FLAG_OF = 5'b00100;
    localparam fflags_t FLAG_UF = 5'b00010;
    localparam fflags_t FLAG_NX = 5'b00001;

    localparam fexp_t EXP_BIAS = 8'd127;
    localparam fexp_t EXP_MAX  = 8'hff;

    localparam fp32_t FP32_QNAN = 32'h7fc0_0000;
    localparam fp32_t FP32_MAXF = 32'h7f7f_ffff;
    localparam fp32_t FP32_INF  = 32'h7f80_0000;   // no sign

    // sign bit on top of an unsigned constant
    function automatic fp32_t fp32_signed(input logic s, input fp32_t mag);
        return mag | {s, 31'd0};
    endfunction

endpackage

`default_nettype wire

//--- logic/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int ROB_IDX_W = 6;   // msb is the wrap bit, 32 entries
    localparam int PREG_W    = 7;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [PREG_W-1:0]    preg_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } redirect_t;

    // true when a is strictly older than b
    function automatic logic rob_older(input rob_idx_t a, input rob_idx_t b);
        if (a[ROB_IDX_W-1] == b[ROB_IDX_W-1]) begin
            return a[ROB_IDX_W-2:0] < b[ROB_IDX_W-2:0];
        end
        return a[ROB_IDX_W-2:0] > b[ROB_IDX_W-2:0];   // wrapped
    endfunction

    // anything not older than the redirect point dies
    function automatic logic rob_killed(input redirect_t r, input rob_idx_t idx);
        return r.valid && !rob_older(idx, r.rob_idx);
    endfunction

endpackage

`default_nettype wire
